//--- verilog/board_bus_pkg.sv
package board_bus_pkg;

    // bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // data RAM window
    localparam logic [addr_w-1:0] ram_base = 64'h0000_0000_0000_1000;
    localparam int ram_words = 1024;
    localparam int ram_idx_w = $clog2(ram_words);

    // single registers
    localparam logic [addr_w-1:0] key_addr = 64'h0000_0000_0000_2000;
    localparam logic [addr_w-1:0] art_addr = 64'h0000_0000_0000_2008;

    // SD controller registers and sector window
    localparam logic [addr_w-1:0] sdc_addr_reg  = 64'h0000_0000_0000_2010;
    localparam logic [addr_w-1:0] sdc_read_reg  = 64'h0000_0000_0000_2018;
    localparam logic [addr_w-1:0] sdc_ready_reg = 64'h0000_0000_0000_2020;
    localparam logic [addr_w-1:0] sdc_avail_reg = 64'h0000_0000_0000_2028;
    localparam logic [addr_w-1:0] sdc_base      = 64'h0000_0000_0000_3000;
    localparam int sector_bytes = 512;
    localparam int sector_idx_w = $clog2(sector_bytes);
    localparam int sd_addr_w    = 32;

    // load opcodes, bit 2 marks the unsigned forms
    typedef enum logic [2:0] {
        load_lb  = 3'b000,
        load_lh  = 3'b001,
        load_lw  = 3'b010,
        load_ld  = 3'b011,
        load_lbu = 3'b100,
        load_lhu = 3'b101,
        load_lwu = 3'b110
    } load_type_e;

    typedef enum logic [2:0] {
        store_sb = 3'b000,
        store_sh = 3'b001,
        store_sw = 3'b010,
        store_sd = 3'b011
    } store_type_e;

    typedef enum logic [1:0] {
        sd_idle,
        sd_reading,
        sd_full
    } sd_buf_state_e;

endpackage

//--- verilog/bus_target_if.sv
`timescale 1ns/1ps

interface bus_target_if;

    // decoded region hit and raw CPU strobes
    logic sel;
    logic read_en;
    logic write_en;
    logic [board_bus_pkg::addr_w-1:0] addr;
    logic [board_bus_pkg::data_w-1:0] wdata;
    board_bus_pkg::load_type_e  rtype;
    board_bus_pkg::store_type_e wtype;

    // response, rdone is a one-cycle pulse with rdata valid
    logic [board_bus_pkg::data_w-1:0] rdata;
    logic rdone;

    modport fabric (
        output sel,
        output read_en,
        output write_en,
        output addr,
        output wdata,
        output rtype,
        output wtype,
        input  rdata,
        input  rdone
    );

    modport target (
        input  sel,
        input  read_en,
        input  write_en,
        input  addr,
        input  wdata,
        input  rtype,
        input  wtype,
        output rdata,
        output rdone
    );

endinterface

//--- verilog/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic [board_bus_pkg::addr_w-1:0] bus_address,
    input  logic [board_bus_pkg::data_w-1:0] bus_write_data,
    input  logic bus_write_enable,
    input  logic bus_read_enable,
    input  logic [2:0] bus_read_type,
    input  logic [2:0] bus_write_type,
    input  logic [7:0] key_ascii,
    output logic [board_bus_pkg::data_w-1:0] bus_read_data,
    output logic bus_read_done,
    output logic uart_write,
    output logic [7:0] uart_data,
    bus_target_if.fabric ram_bus,
    bus_target_if.fabric sd_bus
);

    logic ram_sel;
    logic key_sel;
    logic art_sel;
    logic sdc_sel;
    logic rsp_valid;
    logic [board_bus_pkg::data_w-1:0] rsp_data;
    logic art_wr;
    logic art_wr_d;

    // address map decode
    assign ram_sel = (bus_address >= board_bus_pkg::ram_base) &&
                     (bus_address < board_bus_pkg::ram_base + board_bus_pkg::ram_words * 4);
    assign key_sel = (bus_address == board_bus_pkg::key_addr);
    assign art_sel = (bus_address == board_bus_pkg::art_addr);
    assign sdc_sel = (bus_address == board_bus_pkg::sdc_addr_reg) ||
                     (bus_address == board_bus_pkg::sdc_read_reg) ||
                     (bus_address == board_bus_pkg::sdc_ready_reg) ||
                     (bus_address == board_bus_pkg::sdc_avail_reg) ||
                     ((bus_address >= board_bus_pkg::sdc_base) &&
                      (bus_address < board_bus_pkg::sdc_base + board_bus_pkg::sector_bytes));

    assign ram_bus.sel      = ram_sel;
    assign ram_bus.read_en  = bus_read_enable;
    assign ram_bus.write_en = bus_write_enable;
    assign ram_bus.addr     = bus_address;
    assign ram_bus.wdata    = bus_write_data;
    assign ram_bus.rtype    = board_bus_pkg::load_type_e'(bus_read_type);
    assign ram_bus.wtype    = board_bus_pkg::store_type_e'(bus_write_type);

    assign sd_bus.sel      = sdc_sel;
    assign sd_bus.read_en  = bus_read_enable;
    assign sd_bus.write_en = bus_write_enable;
    assign sd_bus.addr     = bus_address;
    assign sd_bus.wdata    = bus_write_data;
    assign sd_bus.rtype    = board_bus_pkg::load_type_e'(bus_read_type);
    assign sd_bus.wtype    = board_bus_pkg::store_type_e'(bus_write_type);

    // read return mux
    always_comb begin
        rsp_valid = 1'b0;
        rsp_data  = '0;
        if (ram_sel) begin
            rsp_valid = ram_bus.rdone;
            rsp_data  = ram_bus.rdata;
        end else if (sdc_sel) begin
            rsp_valid = sd_bus.rdone;
            rsp_data  = sd_bus.rdata;
        end else if (key_sel) begin
            rsp_valid = 1'b1;
            rsp_data  = {{(board_bus_pkg::data_w - 8){1'b0}}, key_ascii};
        end else begin
            // console and unmapped addresses read as zero
            rsp_valid = 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
        end else if (bus_read_enable) begin
            bus_read_done <= 1'b0;
        end else if (!bus_read_done && rsp_valid) begin
            bus_read_done <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!bus_read_done && rsp_valid) begin
            bus_read_data <= rsp_data;
        end
    end

    // console strobe, one pulse per write even if held
    assign art_wr = bus_write_enable && art_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            art_wr_d   <= 1'b0;
            uart_write <= 1'b0;
        end else begin
            art_wr_d   <= art_wr;
            uart_write <= art_wr && !art_wr_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (art_wr && !art_wr_d) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    // regions of the map must never overlap
    a_one_region: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $onehot0({ram_sel, key_sel, art_sel, sdc_sel}));

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic CLOCK_50,
    input  logic KEY0,
    bus_target_if.target bus
);

    logic [31:0] mem [0:board_bus_pkg::ram_words-1];

    logic [board_bus_pkg::addr_w-1:0] rel_addr;
    logic [board_bus_pkg::ram_idx_w-1:0] idx;
    logic [1:0] off;
    logic rd_req;
    logic wr_req;
    logic [63:0] shifted;
    logic [63:0] size_mask;

    // second beat of ld and sd
    logic ld_pending;
    logic sd_pending;
    logic [board_bus_pkg::ram_idx_w-1:0] ld_idx;
    logic [board_bus_pkg::ram_idx_w-1:0] sd_idx;
    logic [31:0] sd_hi;

    assign rel_addr = bus.addr - board_bus_pkg::ram_base;
    assign idx      = rel_addr[board_bus_pkg::ram_idx_w+1:2];
    assign off      = rel_addr[1:0];
    assign rd_req   = bus.sel && bus.read_en;
    assign wr_req   = bus.sel && bus.write_en;

    // addressed bytes moved down to bit 0
    always_comb begin
        shifted = {32'd0, mem[idx]} >> {off, 3'b000};
        case (bus.rtype)
            board_bus_pkg::load_lb,
            board_bus_pkg::load_lbu: size_mask = 64'h0000_0000_0000_00ff;
            board_bus_pkg::load_lh,
            board_bus_pkg::load_lhu: size_mask = 64'h0000_0000_0000_ffff;
            default:                 size_mask = 64'h0000_0000_ffff_ffff;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ld_pending <= 1'b0;
            sd_pending <= 1'b0;
            bus.rdone  <= 1'b0;
        end else begin
            ld_pending <= rd_req && (bus.rtype == board_bus_pkg::load_ld);
            sd_pending <= wr_req && (bus.wtype == board_bus_pkg::store_sd);
            bus.rdone  <= (rd_req && (bus.rtype != board_bus_pkg::load_ld)) || ld_pending;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_req) begin
            if (bus.rtype == board_bus_pkg::load_ld) begin
                bus.rdata[31:0] <= mem[idx];
                ld_idx          <= idx + 1'b1;
            end else begin
                bus.rdata <= shifted & size_mask;
            end
        end
        // upper word of ld, lower address stays in the low half
        if (ld_pending) begin
            bus.rdata[63:32] <= mem[ld_idx];
        end

        if (sd_pending) begin
            mem[sd_idx] <= sd_hi;
        end else if (wr_req) begin
            case (bus.wtype)
                board_bus_pkg::store_sb: mem[idx][{off, 3'b000} +: 8] <= bus.wdata[7:0];
                board_bus_pkg::store_sh: mem[idx][{off[1], 4'b0000} +: 16] <= bus.wdata[15:0];
                board_bus_pkg::store_sw: mem[idx] <= bus.wdata[31:0];
                default: begin
                    mem[idx] <= bus.wdata[31:0];
                    sd_hi    <= bus.wdata[63:32];
                    sd_idx   <= idx + 1'b1;
                end
            endcase
        end
    end

    // CPU must align half-word stores
    a_sh_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        wr_req && (bus.wtype == board_bus_pkg::store_sh) |-> !off[0]);

endmodule

//--- verilog/sd_sector_buffer.sv
`timescale 1ns/1ps

module sd_sector_buffer (
    input  logic CLOCK_50,
    input  logic KEY0,
    bus_target_if.target bus,
    output logic sd_rd_start,
    output logic [board_bus_pkg::sd_addr_w-1:0] sd_addr,
    input  logic sd_ready,
    input  logic sd_byte_available,
    input  logic [7:0] sd_dout
);

    logic [7:0] cache [0:board_bus_pkg::sector_bytes-1];

    board_bus_pkg::sd_buf_state_e state;
    logic [board_bus_pkg::sector_idx_w:0] byte_index;
    logic byte_avail_d;
    logic byte_rise;
    logic rd_req;
    logic wr_req;
    logic start_req;
    logic capture;
    logic in_window;
    logic [board_bus_pkg::addr_w-1:0] win_off;
    logic [board_bus_pkg::sector_idx_w-1:0] win_idx;

    assign rd_req    = bus.sel && bus.read_en;
    assign wr_req    = bus.sel && bus.write_en;
    assign start_req = wr_req && (bus.addr == board_bus_pkg::sdc_read_reg);
    assign byte_rise = sd_byte_available && !byte_avail_d;
    assign capture   = (state == board_bus_pkg::sd_reading) && byte_rise && !start_req &&
                       (byte_index != board_bus_pkg::sector_bytes);
    assign in_window = (bus.addr >= board_bus_pkg::sdc_base);
    assign win_off   = bus.addr - board_bus_pkg::sdc_base;
    assign win_idx   = win_off[board_bus_pkg::sector_idx_w-1:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state        <= board_bus_pkg::sd_idle;
            byte_index   <= '0;
            byte_avail_d <= 1'b0;
            sd_rd_start  <= 1'b0;
            sd_addr      <= '0;
            bus.rdone    <= 1'b0;
        end else begin
            byte_avail_d <= sd_byte_available;
            bus.rdone    <= rd_req;
            if (wr_req && (bus.addr == board_bus_pkg::sdc_addr_reg)) begin
                sd_addr <= bus.wdata[board_bus_pkg::sd_addr_w-1:0];
            end
            // held until the controller reports ready
            if (start_req) begin
                sd_rd_start <= 1'b1;
            end else if (sd_ready) begin
                sd_rd_start <= 1'b0;
            end
            if (start_req) begin
                state      <= board_bus_pkg::sd_reading;
                byte_index <= '0;
            end else if (state == board_bus_pkg::sd_reading) begin
                if (byte_index == board_bus_pkg::sector_bytes) begin
                    state      <= board_bus_pkg::sd_full;
                    byte_index <= '0;
                end else if (capture) begin
                    byte_index <= byte_index + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (capture) begin
            cache[byte_index[board_bus_pkg::sector_idx_w-1:0]] <= sd_dout;
        end
        if (rd_req) begin
            if (in_window) begin
                bus.rdata <= {{(board_bus_pkg::data_w - 8){1'b0}}, cache[win_idx]};
            end else begin
                case (bus.addr)
                    board_bus_pkg::sdc_ready_reg: bus.rdata <= {63'd0, sd_ready};
                    board_bus_pkg::sdc_avail_reg:
                        bus.rdata <= {63'd0, state == board_bus_pkg::sd_full};
                    board_bus_pkg::sdc_addr_reg: bus.rdata <= {32'd0, sd_addr};
                    default: bus.rdata <= '0;
                endcase
            end
        end
    end

    // write pointer stays inside the sector
    a_index_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        byte_index <= board_bus_pkg::sector_bytes);

endmodule

//--- verilog/key_irq_ctrl.sv
`timescale 1ns/1ps

module key_irq_ctrl (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic key_pressed,
    input  logic [7:0] key_ascii,
    input  logic interrupt_ack,
    output logic [3:0] interrupt_vector,
    output logic irq_led
);

    logic key_event;
    logic ack_event;

    // keys with no ascii code raise nothing
    assign key_event = key_pressed && (key_ascii != 8'd0);
    assign ack_event = interrupt_ack && (interrupt_vector != 4'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= 4'd0;
            irq_led          <= 1'b0;
        end else if (ack_event) begin
            // acknowledge wins over a new press
            interrupt_vector <= 4'd0;
            irq_led          <= 1'b0;
        end else if (key_event) begin
            interrupt_vector <= 4'd1;
            irq_led          <= 1'b1;
        end
    end

endmodule

//--- verilog/board_bus_top.sv
`timescale 1ns/1ps

module board_bus_top (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic [board_bus_pkg::addr_w-1:0] bus_address,
    input  logic [board_bus_pkg::data_w-1:0] bus_write_data,
    input  logic bus_write_enable,
    input  logic bus_read_enable,
    input  logic [2:0] bus_read_type,
    input  logic [2:0] bus_write_type,
    output logic [board_bus_pkg::data_w-1:0] bus_read_data,
    output logic bus_read_done,
    output logic [3:0] interrupt_vector,
    input  logic interrupt_ack,
    input  logic key_pressed,
    input  logic [7:0] key_ascii,
    output logic uart_write,
    output logic [7:0] uart_data,
    output logic sd_rd_start,
    output logic [board_bus_pkg::sd_addr_w-1:0] sd_addr,
    input  logic sd_ready,
    input  logic sd_byte_available,
    input  logic [7:0] sd_dout,
    output logic irq_led
);

    bus_target_if ram_bus ();
    bus_target_if sd_bus ();

    bus_fabric u_fabric (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_type    (bus_read_type),
        .bus_write_type   (bus_write_type),
        .key_ascii        (key_ascii),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .uart_write       (uart_write),
        .uart_data        (uart_data),
        .ram_bus          (ram_bus.fabric),
        .sd_bus           (sd_bus.fabric)
    );

    data_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus.target)
    );

    sd_sector_buffer u_sd_buf (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus               (sd_bus.target),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout)
    );

    key_irq_ctrl u_key_irq (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_pressed      (key_pressed),
        .key_ascii        (key_ascii),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .irq_led          (irq_led)
    );

endmodule

//--- bench/tb_board_bus.sv
`timescale 1ns/1ps

module tb_board_bus;

    localparam int clk_period = 10;
    localparam int ram_loops = 8;
    localparam int read_limit = 20;
    // cycle budget, SD part dominates with its byte feed and window reads
    localparam int ram_cycles = ram_loops * 100;
    localparam int sd_cycles = board_bus_pkg::sector_bytes * 8;
    localparam int watchdog_ns = (ram_cycles + sd_cycles + 1000) * clk_period;

    logic CLOCK_50;
    logic KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic bus_write_enable;
    logic bus_read_enable;
    logic [2:0] bus_read_type;
    logic [2:0] bus_write_type;
    logic [63:0] bus_read_data;
    logic bus_read_done;
    logic [3:0] interrupt_vector;
    logic interrupt_ack;
    logic key_pressed;
    logic [7:0] key_ascii;
    logic uart_write;
    logic [7:0] uart_data;
    logic sd_rd_start;
    logic [31:0] sd_addr;
    logic sd_ready;
    logic sd_byte_available;
    logic [7:0] sd_dout;
    logic irq_led;

    logic [31:0] lfsr;
    logic [7:0] ram_model [0:4*board_bus_pkg::ram_words-1];
    logic [7:0] sd_model [0:board_bus_pkg::sector_bytes-1];
    logic [63:0] exp_rd;
    logic [7:0] exp_uart;
    logic [31:0] exp_sd_addr;
    int uart_pulses;
    int exp_pulses;
    logic chk_idle;
    logic chk_uart;

    board_bus_top UUT (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_type     (bus_read_type),
        .bus_write_type    (bus_write_type),
        .bus_read_data     (bus_read_data),
        .bus_read_done     (bus_read_done),
        .interrupt_vector  (interrupt_vector),
        .interrupt_ack     (interrupt_ack),
        .key_pressed       (key_pressed),
        .key_ascii         (key_ascii),
        .uart_write        (uart_write),
        .uart_data         (uart_data),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .sd_ready          (sd_ready),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout),
        .irq_led           (irq_led)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(clk_period / 2) CLOCK_50 = ~CLOCK_50;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_fail(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        abort_run();
    endtask

    // galois LFSR, right shifting
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [63:0] ram_addr(input int idx, input int off);
        return board_bus_pkg::ram_base + idx * 4 + off;
    endfunction

    function automatic logic [31:0] word32(input int idx);
        return {ram_model[4*idx+3], ram_model[4*idx+2], ram_model[4*idx+1], ram_model[4*idx]};
    endfunction

    // bytes above the word end read as zero
    function automatic logic [63:0] half_of(input int idx, input int off);
        logic [7:0] upper;
        upper = (off < 3) ? ram_model[4*idx+off+1] : 8'd0;
        return {48'd0, upper, ram_model[4*idx+off]};
    endfunction

    task automatic bus_write(input logic [63:0] addr, input logic [2:0] wtype,
                             input logic [63:0] data, input int hold);
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_type   <= wtype;
        bus_write_data   <= data;
        bus_write_enable <= 1'b1;
        repeat (hold) @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
    endtask

    task automatic ram_store(input int idx, input int off, input logic [2:0] wtype,
                             input logic [63:0] data);
        int nbytes;
        case (wtype)
            board_bus_pkg::store_sb: nbytes = 1;
            board_bus_pkg::store_sh: nbytes = 2;
            board_bus_pkg::store_sw: nbytes = 4;
            default:                 nbytes = 8;
        endcase
        for (int b = 0; b < nbytes; b++) begin
            ram_model[4*idx+off+b] = data[8*b +: 8];
        end
        bus_write(ram_addr(idx, off), wtype, data, 1);
        // idle cycle for the second beat of sd
        if (wtype == board_bus_pkg::store_sd) begin
            @(posedge CLOCK_50);
        end
    endtask

    task automatic bus_read(input logic [63:0] addr, input logic [2:0] rtype,
                            input logic [63:0] expected);
        int waited;
        waited = 0;
        @(posedge CLOCK_50);
        exp_rd = expected;
        bus_address     <= addr;
        bus_read_type   <= rtype;
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        @(negedge CLOCK_50);
        while (!bus_read_done) begin
            waited++;
            if (waited > read_limit) begin
                $display("bus_read_done never came back after a read of address %h", addr);
                abort_run();
            end
            @(negedge CLOCK_50);
        end
    endtask

    always @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_pulses <= 0;
        end else if (uart_write) begin
            uart_pulses <= uart_pulses + 1;
        end
    end

    a_read_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(bus_read_done) |-> bus_read_data == exp_rd)
        else value_fail($sformatf("read data %h, expected %h", bus_read_data, exp_rd));
    a_done_falls: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable |=> !bus_read_done)
        else value_fail("bus_read_done stayed high after a read strobe");
    a_reset_idle: assert property (@(posedge CLOCK_50)
        chk_idle |-> !uart_write && !sd_rd_start && interrupt_vector == 4'd0 && !irq_led &&
                     bus_read_done)
        else value_fail("outputs not idle after reset");
    a_uart_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |-> uart_data == exp_uart)
        else value_fail($sformatf("uart_data %h, expected %h", uart_data, exp_uart));
    a_uart_count: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        chk_uart |-> uart_pulses == exp_pulses)
        else value_fail($sformatf("%0d console pulses, expected %0d", uart_pulses, exp_pulses));
    a_irq_set: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        key_pressed && key_ascii != 8'd0 && !interrupt_ack |=> interrupt_vector == 4'd1 && irq_led)
        else value_fail("key press did not raise interrupt vector 1");
    a_irq_quiet: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        key_pressed && key_ascii == 8'd0 && interrupt_vector == 4'd0 && !interrupt_ack
        |=> interrupt_vector == 4'd0)
        else value_fail("key with zero code raised an interrupt");
    a_irq_clear: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        interrupt_ack && interrupt_vector != 4'd0 |=> interrupt_vector == 4'd0 && !irq_led)
        else value_fail("acknowledge did not clear the interrupt");
    a_sd_start: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && bus_address == board_bus_pkg::sdc_read_reg |=> sd_rd_start)
        else value_fail("sd_rd_start not raised by a read request");
    a_sd_stop: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_ready && sd_rd_start && !bus_write_enable |=> !sd_rd_start)
        else value_fail("sd_rd_start still high after sd_ready");
    a_sd_addr: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |-> sd_addr == exp_sd_addr)
        else value_fail($sformatf("sd_addr %h, expected %h", sd_addr, exp_sd_addr));

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        abort_run();
    end

    initial begin : main
        logic [63:0] r;
        logic [63:0] d;
        logic [7:0] code;
        int idx;
        int off;

        lfsr              = 32'h93b40cc8;
        KEY0              = 1'b0;
        bus_address       = '0;
        bus_write_data    = '0;
        bus_write_enable  = 1'b0;
        bus_read_enable   = 1'b0;
        bus_read_type     = 3'd0;
        bus_write_type    = 3'd0;
        interrupt_ack     = 1'b0;
        key_pressed       = 1'b0;
        key_ascii         = 8'd0;
        sd_ready          = 1'b0;
        sd_byte_available = 1'b0;
        sd_dout           = 8'd0;
        exp_rd            = '0;
        exp_uart          = 8'd0;
        exp_sd_addr       = 32'd0;
        exp_pulses        = 0;
        chk_idle          = 1'b0;
        chk_uart          = 1'b0;

        repeat (2) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        chk_idle = 1'b1;
        @(negedge CLOCK_50);
        chk_idle = 1'b0;
        bus_read(board_bus_pkg::sdc_avail_reg, board_bus_pkg::load_lbu, 64'd0);

        // word stores, then word and sub-word loads
        for (int n = 0; n < ram_loops; n++) begin
            rand_bits(10, r);
            idx = r;
            rand_bits(32, d);
            ram_store(idx, 0, board_bus_pkg::store_sw, d);
            bus_read(ram_addr(idx, 0), board_bus_pkg::load_lw, {32'd0, word32(idx)});
            for (int o = 0; o < 4; o++) begin
                bus_read(ram_addr(idx, o), board_bus_pkg::load_lbu,
                         {56'd0, ram_model[4*idx+o]});
                bus_read(ram_addr(idx, o), board_bus_pkg::load_lhu, half_of(idx, o));
            end
        end

        // byte lane merges and double accesses
        for (int n = 0; n < ram_loops; n++) begin
            rand_bits(10, r);
            idx = r;
            rand_bits(32, d);
            ram_store(idx, 0, board_bus_pkg::store_sw, d);
            rand_bits(2, r);
            off = r;
            rand_bits(8, d);
            ram_store(idx, off, board_bus_pkg::store_sb, d);
            rand_bits(1, r);
            off = r * 2;
            rand_bits(16, d);
            ram_store(idx, off, board_bus_pkg::store_sh, d);
            bus_read(ram_addr(idx, 0), board_bus_pkg::load_lw, {32'd0, word32(idx)});
            // even word so the pair stays inside the RAM
            rand_bits(9, r);
            idx = r * 2;
            rand_bits(64, d);
            ram_store(idx, 0, board_bus_pkg::store_sd, d);
            bus_read(ram_addr(idx, 0), board_bus_pkg::load_ld, {word32(idx + 1), word32(idx)});
        end

        // keyboard register and interrupt
        rand_bits(8, r);
        code = (r[7:0] == 8'd0) ? 8'h41 : r[7:0];
        @(posedge CLOCK_50);
        key_ascii <= code;
        bus_read(board_bus_pkg::key_addr, board_bus_pkg::load_lbu, {56'd0, code});
        @(posedge CLOCK_50);
        key_ascii   <= 8'd0;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        key_ascii   <= code;
        @(posedge CLOCK_50);
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        repeat (2) @(posedge CLOCK_50);
        interrupt_ack <= 1'b1;
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b0;

        // console writes, strobe held one and two cycles
        for (int h = 1; h <= 2; h++) begin
            rand_bits(64, d);
            exp_uart = d[7:0];
            bus_write(board_bus_pkg::art_addr, board_bus_pkg::store_sw, d, h);
            repeat (3) @(posedge CLOCK_50);
            exp_pulses++;
            @(negedge CLOCK_50);
            chk_uart = 1'b1;
            @(negedge CLOCK_50);
            chk_uart = 1'b0;
        end

        // SD sector read
        rand_bits(32, d);
        exp_sd_addr = d[31:0];
        bus_write(board_bus_pkg::sdc_addr_reg, board_bus_pkg::store_sw, d, 1);
        bus_write(board_bus_pkg::sdc_read_reg, board_bus_pkg::store_sw, 64'd1, 1);
        repeat (3) @(posedge CLOCK_50);
        sd_ready <= 1'b1;
        @(posedge CLOCK_50);
        sd_ready <= 1'b0;
        for (int i = 0; i < board_bus_pkg::sector_bytes; i++) begin
            rand_bits(8, r);
            sd_model[i] = r[7:0];
            @(posedge CLOCK_50);
            sd_dout           <= r[7:0];
            sd_byte_available <= 1'b1;
            @(posedge CLOCK_50);
            sd_byte_available <= 1'b0;
        end
        repeat (3) @(posedge CLOCK_50);
        bus_read(board_bus_pkg::sdc_avail_reg, board_bus_pkg::load_lbu, 64'd1);
        for (int i = 0; i < board_bus_pkg::sector_bytes; i++) begin
            bus_read(board_bus_pkg::sdc_base + i, board_bus_pkg::load_lbu, {56'd0, sd_model[i]});
        end
        bus_write(board_bus_pkg::sdc_read_reg, board_bus_pkg::store_sw, 64'd1, 1);
        bus_read(board_bus_pkg::sdc_avail_reg, board_bus_pkg::load_lbu, 64'd0);

        repeat (5) @(posedge CLOCK_50);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- board_bus_top.f
verilog/board_bus_pkg.sv
verilog/bus_target_if.sv
verilog/bus_fabric.sv
verilog/data_ram.sv
verilog/sd_sector_buffer.sv
verilog/key_irq_ctrl.sv
verilog/board_bus_top.sv
bench/tb_board_bus.sv

//--- Bender.yml
package:
  name: board_bus

sources:
  - verilog/board_bus_pkg.sv
  - verilog/bus_target_if.sv
  - verilog/bus_fabric.sv
  - verilog/data_ram.sv
  - verilog/sd_sector_buffer.sv
  - verilog/key_irq_ctrl.sv
  - verilog/board_bus_top.sv
  - target: test
    files:
      - bench/tb_board_bus.sv
